//--- verilog/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Fetch address and instruction widths
`define ICACHE_VADDR_WIDTH 16
`define ICACHE_INSTR_WIDTH 32

// Direct-mapped geometry
`define ICACHE_SETS 16
`define ICACHE_WORDS_PER_BLOCK 4
`define ICACHE_INDEX_WIDTH 4
`define ICACHE_OFFSET_WIDTH 4
`define ICACHE_TAG_WIDTH 8
`define ICACHE_WORD_SEL_WIDTH 2
`define ICACHE_BYTE_SEL_WIDTH (`ICACHE_OFFSET_WIDTH - `ICACHE_WORD_SEL_WIDTH)

// Replay FIFO depth
`define ICACHE_FIFO_ELS 8

// Cycles from issue to data or miss
`define ICACHE_ISSUE_LATENCY 2

`endif

//--- verilog/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

  // Fields of a fetch address, tag in the top bits
  typedef struct packed {
    logic [`ICACHE_TAG_WIDTH-1:0]      tag;
    logic [`ICACHE_INDEX_WIDTH-1:0]    index;
    logic [`ICACHE_WORD_SEL_WIDTH-1:0] word;
    logic [`ICACHE_BYTE_SEL_WIDTH-1:0] byte_sel;
  } icache_addr_fields_s;

  // Same word seen as a raw address or split into fields
  typedef union packed {
    logic [`ICACHE_VADDR_WIDTH-1:0] raw;
    icache_addr_fields_s            f;
  } icache_addr_u;

  // Memory command address, one block
  typedef struct packed {
    logic [`ICACHE_TAG_WIDTH-1:0]   tag;
    logic [`ICACHE_INDEX_WIDTH-1:0] index;
  } block_addr_t;

  // One array write per response beat
  typedef struct packed {
    logic                              v;
    logic [`ICACHE_INDEX_WIDTH-1:0]    index;
    logic [`ICACHE_TAG_WIDTH-1:0]      tag;
    logic [`ICACHE_WORD_SEL_WIDTH-1:0] word;
    logic [`ICACHE_INSTR_WIDTH-1:0]    data;
    // Final beat also sets tag and valid
    logic                              last;
  } fill_wr_s;

endpackage

//--- verilog/fetch_replay_fifo.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module fetch_replay_fifo
  (input                                clk_i
   , input                              reset_i

   , input icache_pkg::icache_addr_u    vaddr_i
   , input                              vaddr_v_i
   , output logic                       vaddr_ready_o

   , input                              issue_ready_i
   , output icache_pkg::icache_addr_u   issue_addr_o
   , output logic                       issue_v_o

   , input                              commit_i
   , input                              roll_i
   );

  import icache_pkg::*;

  localparam int slot_width_lp = $clog2(`ICACHE_FIFO_ELS);
  localparam int ptr_width_lp  = slot_width_lp + 1;
  localparam logic [ptr_width_lp-1:0] els_lp = ptr_width_lp'(`ICACHE_FIFO_ELS);

  icache_addr_u mem_r [`ICACHE_FIFO_ELS-1:0];

  // Extra wrap bit on each pointer
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] iptr_r;
  logic [ptr_width_lp-1:0] cptr_r;
  logic [ptr_width_lp-1:0] count;
  logic enq;
  logic issue;

  // Entries stay counted until their data comes back
  assign count         = wptr_r - cptr_r;
  assign vaddr_ready_o = (count < els_lp);
  assign enq           = vaddr_v_i & vaddr_ready_o;

  assign issue_v_o        = (iptr_r != wptr_r);
  assign issue_addr_o.raw = mem_r[iptr_r[slot_width_lp-1:0]].raw;
  assign issue            = issue_v_o & issue_ready_i;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r[slot_width_lp-1:0]].raw <= vaddr_i.raw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      iptr_r <= '0;
      cptr_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (commit_i) begin
        cptr_r <= cptr_r + 1'b1;
      end
      // Replay from the oldest entry still waiting for data
      if (roll_i) begin
        iptr_r <= cptr_r;
      end else if (issue) begin
        iptr_r <= iptr_r + 1'b1;
      end
    end
  end

  // Data only returns for entries already issued
  assert property (@(posedge clk_i) disable iff (reset_i)
    commit_i |-> (cptr_r != iptr_r));

  // Occupancy never passes the depth
  assert property (@(posedge clk_i) disable iff (reset_i)
    count <= els_lp);

endmodule

//--- verilog/fill_beat_counter.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module fill_beat_counter
  (input                                      clk_i
   , input                                    reset_i

   , input                                    beat_v_i
   , input                                    beat_last_i

   , output logic [`ICACHE_WORD_SEL_WIDTH-1:0] beat_idx_o
   , output logic                             fill_done_o
   );

  localparam int sel_width_lp = `ICACHE_WORD_SEL_WIDTH;
  localparam logic [sel_width_lp-1:0] last_beat_lp = sel_width_lp'(`ICACHE_WORDS_PER_BLOCK - 1);

  logic [sel_width_lp-1:0] count_r;

  assign beat_idx_o  = count_r;
  assign fill_done_o = beat_v_i & (count_r == last_beat_lp);

  // Wraps back to word zero after the last beat
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (beat_v_i) begin
      count_r <= count_r + 1'b1;
    end
  end

  // Memory marks the fourth beat and no other
  assert property (@(posedge clk_i) disable iff (reset_i)
    beat_v_i |-> (beat_last_i == (count_r == last_beat_lp)));

endmodule

//--- verilog/icache_lookup.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_lookup
  (input                                      clk_i
   , input                                    reset_i

   , input icache_pkg::icache_addr_u          issue_addr_i
   , input                                    issue_v_i
   , output logic                             issue_ready_o

   , input                                    fill_busy_i
   , input icache_pkg::fill_wr_s              fill_wr_i

   , output logic [`ICACHE_INSTR_WIDTH-1:0]   data_o
   , output logic                             data_v_o
   , output logic                             miss_o
   , output icache_pkg::block_addr_t          miss_addr_o
   );

  import icache_pkg::*;

  logic [`ICACHE_TAG_WIDTH-1:0]   tag_mem  [`ICACHE_SETS-1:0];
  logic [`ICACHE_INSTR_WIDTH-1:0] data_mem [`ICACHE_SETS-1:0][`ICACHE_WORDS_PER_BLOCK-1:0];
  logic [`ICACHE_SETS-1:0]        valid_r;

  icache_addr_u                   s1_addr_r;
  logic                           s1_v_r;
  logic [`ICACHE_TAG_WIDTH-1:0]   s1_tag_r;
  logic                           s1_valid_r;
  logic [`ICACHE_INSTR_WIDTH-1:0] s1_data_r;
  logic issue;
  logic hit;
  logic s1_live;

  // Stall from the miss pulse until the fill is done
  assign issue_ready_o = ~fill_busy_i & ~miss_o;
  assign issue         = issue_v_i & issue_ready_o;

  always_ff @(posedge clk_i) begin
    if (fill_wr_i.v) begin
      data_mem[fill_wr_i.index][fill_wr_i.word] <= fill_wr_i.data;
      if (fill_wr_i.last) begin
        tag_mem[fill_wr_i.index] <= fill_wr_i.tag;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (fill_wr_i.v & fill_wr_i.last) begin
      valid_r[fill_wr_i.index] <= 1'b1;
    end
  end

  // Stage one reads the arrays
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else begin
      s1_v_r <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_addr_r  <= issue_addr_i;
    s1_tag_r   <= tag_mem[issue_addr_i.f.index];
    s1_valid_r <= valid_r[issue_addr_i.f.index];
    s1_data_r  <= data_mem[issue_addr_i.f.index][issue_addr_i.f.word];
  end

  // Stage two compares the tag
  assign hit = s1_valid_r & (s1_tag_r == s1_addr_r.f.tag);

  // Younger entry is poisoned when the older one misses
  assign s1_live = s1_v_r & ~miss_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_o <= 1'b0;
      miss_o   <= 1'b0;
    end else begin
      data_v_o <= s1_live & hit;
      miss_o   <= s1_live & ~hit;
    end
  end

  always_ff @(posedge clk_i) begin
    data_o            <= s1_data_r;
    miss_addr_o.tag   <= s1_addr_r.f.tag;
    miss_addr_o.index <= s1_addr_r.f.index;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_o && miss_o));

endmodule

//--- verilog/icache_fill_fsm.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_fill_fsm
  (input                                       clk_i
   , input                                     reset_i

   , input                                     miss_i
   , input icache_pkg::block_addr_t            miss_addr_i

   , output icache_pkg::block_addr_t           mem_cmd_addr_o
   , output logic                              mem_cmd_v_o
   , input                                     mem_cmd_ready_and_i

   , input [`ICACHE_INSTR_WIDTH-1:0]           mem_resp_data_i
   , input                                     mem_resp_v_i
   , output logic                              mem_resp_ready_and_o

   , input [`ICACHE_WORD_SEL_WIDTH-1:0]        beat_idx_i
   , input                                     fill_done_i

   , output icache_pkg::fill_wr_s              fill_wr_o
   , output logic                              fill_busy_o
   );

  import icache_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_send_cmd,
    e_recv
  } state_e;

  state_e      state_r;
  state_e      state_n;
  block_addr_t addr_r;
  logic        beat;

  assign mem_cmd_v_o          = (state_r == e_send_cmd);
  assign mem_cmd_addr_o       = addr_r;
  assign mem_resp_ready_and_o = (state_r == e_recv);
  assign fill_busy_o          = (state_r != e_idle);
  assign beat                 = mem_resp_v_i & mem_resp_ready_and_o;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (miss_i) begin
          state_n = e_send_cmd;
        end
      end
      e_send_cmd: begin
        if (mem_cmd_ready_and_i) begin
          state_n = e_recv;
        end
      end
      e_recv: begin
        if (fill_done_i) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // Block address held for the whole fill
  always_ff @(posedge clk_i) begin
    if ((state_r == e_idle) && miss_i) begin
      addr_r <= miss_addr_i;
    end
  end

  // One word write per beat at the latched block address
  always_comb begin
    fill_wr_o.v     = beat;
    fill_wr_o.index = addr_r.index;
    fill_wr_o.tag   = addr_r.tag;
    fill_wr_o.word  = beat_idx_i;
    fill_wr_o.data  = mem_resp_data_i;
    fill_wr_o.last  = fill_done_i;
  end

  // Lookup stalls issue for the whole fill
  assert property (@(posedge clk_i) disable iff (reset_i)
    miss_i |-> !fill_busy_o);

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top
  (input                                      clk_i
   , input                                    reset_i

   , input [`ICACHE_VADDR_WIDTH-1:0]          vaddr_i
   , input                                    vaddr_v_i
   , output logic                             vaddr_ready_o

   , output logic [`ICACHE_INSTR_WIDTH-1:0]   data_o
   , output logic                             data_v_o

   , output icache_pkg::block_addr_t          mem_cmd_addr_o
   , output logic                             mem_cmd_v_o
   , input                                    mem_cmd_ready_and_i

   , input [`ICACHE_INSTR_WIDTH-1:0]          mem_resp_data_i
   , input                                    mem_resp_v_i
   , output logic                             mem_resp_ready_and_o
   , input                                    mem_resp_last_i
   );

  import icache_pkg::*;

  icache_addr_u                      issue_addr;
  logic                              issue_v;
  logic                              issue_ready;
  logic                              miss;
  block_addr_t                       miss_addr;
  fill_wr_s                          fill_wr;
  logic                              fill_busy;
  logic [`ICACHE_WORD_SEL_WIDTH-1:0] beat_idx;
  logic                              fill_done;

  // Returned data retires the FIFO entry, a miss rolls it back
  fetch_replay_fifo i_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.vaddr_i(vaddr_i)
     ,.vaddr_v_i(vaddr_v_i)
     ,.vaddr_ready_o(vaddr_ready_o)
     ,.issue_ready_i(issue_ready)
     ,.issue_addr_o(issue_addr)
     ,.issue_v_o(issue_v)
     ,.commit_i(data_v_o)
     ,.roll_i(miss)
     );

  icache_lookup i_lookup
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.issue_addr_i(issue_addr)
     ,.issue_v_i(issue_v)
     ,.issue_ready_o(issue_ready)
     ,.fill_busy_i(fill_busy)
     ,.fill_wr_i(fill_wr)
     ,.data_o(data_o)
     ,.data_v_o(data_v_o)
     ,.miss_o(miss)
     ,.miss_addr_o(miss_addr)
     );

  icache_fill_fsm i_fill_fsm
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.miss_i(miss)
     ,.miss_addr_i(miss_addr)
     ,.mem_cmd_addr_o(mem_cmd_addr_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_and_i(mem_cmd_ready_and_i)
     ,.mem_resp_data_i(mem_resp_data_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
     ,.beat_idx_i(beat_idx)
     ,.fill_done_i(fill_done)
     ,.fill_wr_o(fill_wr)
     ,.fill_busy_o(fill_busy)
     );

  // Write valid is the beat handshake
  fill_beat_counter i_beat_counter
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.beat_v_i(fill_wr.v)
     ,.beat_last_i(mem_resp_last_i)
     ,.beat_idx_o(beat_idx)
     ,.fill_done_o(fill_done)
     );

endmodule

//--- test/icache_tb_mem.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb_mem
  #(parameter int seed_p = 38)
  (input                                      clk_i
   , input                                    reset_i
   , input                                    stall_en_i

   , input icache_pkg::block_addr_t           mem_cmd_addr_i
   , input                                    mem_cmd_v_i
   , output logic                             mem_cmd_ready_and_o

   , output logic [`ICACHE_INSTR_WIDTH-1:0]   mem_resp_data_o
   , output logic                             mem_resp_v_o
   , input                                    mem_resp_ready_and_i
   , output logic                             mem_resp_last_o
   );

  import icache_pkg::*;

  integer                         seed;
  block_addr_t                    blk_r;
  logic                           cmd_fire;
  logic                           resp_fire;
  logic                           busy;
  logic [2:0]                     beat;
  logic                           stall;
  logic [`ICACHE_VADDR_WIDTH-1:0] byte_addr;

  initial begin
    seed                = seed_p;
    mem_cmd_ready_and_o = 1'b0;
    mem_resp_v_o        = 1'b0;
    mem_resp_last_o     = 1'b0;
    mem_resp_data_o     = '0;
  end

  // Transfers as seen at the rising edge
  always @(posedge clk_i) begin
    cmd_fire  <= mem_cmd_v_i & mem_cmd_ready_and_o;
    resp_fire <= mem_resp_v_o & mem_resp_ready_and_i;
    if (mem_cmd_v_i & mem_cmd_ready_and_o) begin
      blk_r <= mem_cmd_addr_i;
    end
  end

  always @(negedge clk_i) begin
    if (reset_i) begin
      busy = 1'b0;
      beat = '0;
      mem_cmd_ready_and_o <= 1'b0;
      mem_resp_v_o        <= 1'b0;
      mem_resp_last_o     <= 1'b0;
      mem_resp_data_o     <= '0;
    end else begin
      if (cmd_fire) begin
        busy = 1'b1;
        beat = '0;
      end
      if (resp_fire) begin
        beat = beat + 1'b1;
        busy = (beat != 3'd4);
      end
      // One cycle in four held back when stalls are on
      stall = stall_en_i && (($random(seed) & 3) == 0);
      byte_addr = {blk_r, beat[1:0], 2'b00};
      mem_cmd_ready_and_o <= !busy && !stall;
      mem_resp_v_o        <= busy && !stall;
      mem_resp_last_o     <= (beat == 3'd3);
      mem_resp_data_o     <= {~byte_addr, byte_addr};
    end
  end

endmodule

//--- test/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;

  import icache_pkg::*;

  localparam int reset_cycles_lp  = 16;
  localparam int rand_fetches_lp  = 60;
  localparam int stall_fetches_lp = 40;
  localparam int fetch_total_lp   = 5 + rand_fetches_lp + stall_fetches_lp + 6;
  // Four times about nine cycles per missing fetch
  localparam int timeout_lp = 4 * (reset_cycles_lp + 9 * fetch_total_lp);

  logic                           clk_i;
  logic                           reset_i;
  logic [`ICACHE_VADDR_WIDTH-1:0] vaddr_i;
  logic                           vaddr_v_i;
  logic                           vaddr_ready_o;
  logic [`ICACHE_INSTR_WIDTH-1:0] data_o;
  logic                           data_v_o;
  block_addr_t                    mem_cmd_addr_o;
  logic                           mem_cmd_v_o;
  logic                           mem_cmd_ready_and_i;
  logic [`ICACHE_INSTR_WIDTH-1:0] mem_resp_data_i;
  logic                           mem_resp_v_i;
  logic                           mem_resp_ready_and_o;
  logic                           mem_resp_last_i;
  logic                           stall_en;

  integer seed;
  int     errors;
  int     tests;
  int     cycles;
  int     cmd_count;
  int     accepted;
  int     returned;
  int     outstanding;
  int     err_base;
  int     cmd_base;
  logic [`ICACHE_VADDR_WIDTH-1:0] exp_q [$];

  // Sampled at the falling edge for checks at the next rising edge
  logic                           data_chk;
  logic                           stray_data;
  logic [`ICACHE_INSTR_WIDTH-1:0] data_got;
  logic [`ICACHE_INSTR_WIDTH-1:0] data_exp;
  logic                           cmd_chk;
  block_addr_t                    cmd_got;
  block_addr_t                    cmd_exp;
  logic                           ready_got;
  logic                           ready_exp;

  icache_top i_dut (.*);

  icache_tb_mem i_mem
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.stall_en_i(stall_en)
     ,.mem_cmd_addr_i(mem_cmd_addr_o)
     ,.mem_cmd_v_i(mem_cmd_v_o)
     ,.mem_cmd_ready_and_o(mem_cmd_ready_and_i)
     ,.mem_resp_data_o(mem_resp_data_i)
     ,.mem_resp_v_o(mem_resp_v_i)
     ,.mem_resp_ready_and_i(mem_resp_ready_and_o)
     ,.mem_resp_last_o(mem_resp_last_i)
     );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Word at an aligned byte address is its inverse above itself
  function automatic logic [31:0] fetch_word(input logic [15:0] addr);
    logic [15:0] a;
    a = {addr[15:2], 2'b00};
    return {~a, a};
  endfunction

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (mem_cmd_v_o && mem_cmd_ready_and_i) begin
      cmd_count <= cmd_count + 1;
    end
    if (!reset_i) begin
      outstanding <= outstanding + int'(vaddr_v_i && vaddr_ready_o) - int'(data_v_o);
    end
  end

  always @(posedge clk_i) begin
    if (cycles > timeout_lp) begin
      $display("Timeout after %0d cycles, %0d fetches never returned", cycles, exp_q.size());
      $display("ERRORS FOUND");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    data_chk   <= data_v_o && (exp_q.size() != 0);
    stray_data <= data_v_o && (exp_q.size() == 0);
    data_got   <= data_o;
    cmd_chk    <= mem_cmd_v_o;
    cmd_got    <= mem_cmd_addr_o;
    // A miss always belongs to the oldest fetch still waiting
    cmd_exp    <= (exp_q.size() != 0) ? block_addr_t'(exp_q[0][15:4]) : '0;
    ready_got  <= vaddr_ready_o;
    ready_exp  <= (outstanding < `ICACHE_FIFO_ELS);
    if (data_v_o) begin
      returned++;
      if (exp_q.size() != 0) begin
        data_exp <= fetch_word(exp_q.pop_front());
      end
    end
  end

  assert property (@(posedge clk_i) reset_i |=>
      ({data_v_o, mem_cmd_v_o, mem_resp_ready_and_o, vaddr_ready_o} == 4'b0001))
    else begin
      $display("CHECK FAILED t=%0t %s got %b expected 0001", $time,
               "{data_v_o,mem_cmd_v_o,mem_resp_ready_and_o,vaddr_ready_o}",
               $sampled({data_v_o, mem_cmd_v_o, mem_resp_ready_and_o, vaddr_ready_o}));
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) data_chk |-> (data_got == data_exp))
    else begin
      $display("CHECK FAILED t=%0t data_o got %h expected %h", $time, data_got, data_exp);
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) !stray_data)
    else begin
      $display("t=%0t data_v_o pulsed with no fetch outstanding", $time);
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) cmd_chk |-> (cmd_got == cmd_exp))
    else begin
      $display("CHECK FAILED t=%0t mem_cmd_addr_o got %h expected %h", $time, cmd_got, cmd_exp);
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) ready_got == ready_exp)
    else begin
      $display("CHECK FAILED t=%0t vaddr_ready_o got %b expected %b", $time, ready_got, ready_exp);
      errors++;
    end

  // Starts and ends on a falling edge
  task automatic send_fetch(input logic [15:0] addr);
    logic taken;
    taken     = 1'b0;
    vaddr_i   = addr;
    vaddr_v_i = 1'b1;
    while (!taken) begin
      taken = vaddr_ready_o;
      if (taken) begin
        exp_q.push_back(addr);
        accepted++;
      end
      @(negedge clk_i);
    end
    vaddr_v_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic start_test();
    err_base = errors;
    cmd_base = cmd_count;
  endtask

  task automatic end_test(input string name, input int cmds_exp);
    int cmds;
    wait_idle();
    cmds = cmd_count - cmd_base;
    if (cmds_exp >= 0) begin
      assert (cmds == cmds_exp) else begin
        $display("CHECK FAILED t=%0t mem_cmd_v_o transfers got %0d expected %0d",
                 $time, cmds, cmds_exp);
        errors++;
      end
    end
    assert (returned == accepted) else begin
      $display("CHECK FAILED t=%0t data_v_o count got %0d expected %0d",
               $time, returned, accepted);
      errors++;
    end
    tests++;
    $display("Test %0d %s finished, %0d errors", tests, name, errors - err_base);
  endtask

  initial begin
    logic [31:0] rnd;
    seed        = 38;
    errors      = 0;
    tests       = 0;
    cycles      = 0;
    cmd_count   = 0;
    accepted    = 0;
    returned    = 0;
    outstanding = 0;
    reset_i     = 1'b1;
    vaddr_i     = '0;
    vaddr_v_i   = 1'b0;
    stall_en    = 1'b0;
    repeat (reset_cycles_lp) @(negedge clk_i);
    reset_i = 1'b0;

    start_test();
    repeat (4) @(negedge clk_i);
    end_test("reset", 0);

    start_test();
    send_fetch(16'h3a50);
    end_test("cold_miss", 1);

    start_test();
    send_fetch(16'h3a54);
    send_fetch(16'h3a58);
    send_fetch(16'h3a5c);
    end_test("hits", 0);

    start_test();
    repeat (rand_fetches_lp) begin
      rnd = $random(seed);
      send_fetch({rnd[15:2], 2'b00});
    end
    end_test("ordering", -1);

    stall_en = 1'b1;
    start_test();
    repeat (stall_fetches_lp) begin
      rnd = $random(seed);
      send_fetch({rnd[15:2], 2'b00});
    end
    end_test("back_pressure", -1);
    stall_en = 1'b0;

    // Third tag in set 3 so both conflict addresses start cold
    send_fetch(16'h7730);
    wait_idle();
    start_test();
    repeat (3) begin
      send_fetch(16'h1234);
      send_fetch(16'h4538);
    end
    end_test("conflicts", 6);

    $display("Tests %0d, fetches %0d, returned %0d, errors %0d",
             tests, accepted, returned, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/fetch_replay_fifo.sv
verilog/fill_beat_counter.sv
verilog/icache_lookup.sv
verilog/icache_fill_fsm.sv
verilog/icache_top.sv
test/icache_tb_mem.sv
test/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module icache_tb -f filelist.f \
  && { ./obj_dir/Vicache_tb > sim.log 2>&1; cat sim.log; } \
  && grep -q "^NO ERRORS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
